// File: source/kbdPkg.sv
package kbdPkg;

	// One byte as it arrives from the keyboard
	typedef logic [7:0] scanByte_t;

	// Translated key, 0 means no character
	typedef logic [7:0] charCode_t;

	typedef logic [3:0] apbAddr_t;
	typedef logic [31:0] apbWord_t;

	// Position inside an 11-bit PS/2 frame
	typedef enum logic [1:0] {
		idle,
		dataBits,
		parityBit,
		stopBit
	} frameState_t;

	// Register map
	localparam apbAddr_t ADDR_DATA = 4'h0;	// FIFO head, pops on read
	localparam apbAddr_t ADDR_STATUS = 4'h4;	// Flags and count
	localparam apbAddr_t ADDR_ERRORS = 4'h8;	// Bad frame counter

	// Key codes that need special handling
	localparam scanByte_t SCAN_BREAK = 8'hF0;
	localparam scanByte_t SCAN_EXT = 8'hE0;
	localparam scanByte_t SCAN_LSHIFT = 8'h12;
	localparam scanByte_t SCAN_RSHIFT = 8'h59;

endpackage

// File: source/ps2LinkIf.sv
`timescale 1ns/1ps

interface ps2LinkIf;

	logic fallEdge;	// Synchronized PS/2 clock fell
	logic bitVal;	// Data line at that edge
	kbdPkg::scanByte_t rxByte;
	logic parityOk;	// Odd parity over data and parity bit
	logic shiftEn;
	logic clearFrame;

	modport receiver (
		output fallEdge, bitVal, rxByte, parityOk,
		input shiftEn, clearFrame
	);

	modport fsm (
		input fallEdge, bitVal, rxByte, parityOk,
		output shiftEn, clearFrame
	);

endinterface

// File: source/ps2BitReceiver.sv
`timescale 1ns/1ps

module ps2BitReceiver (
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_ps2Clk,
	input  logic i_ps2Data,
	ps2LinkIf.receiver link
);

	logic [1:0] clkSync;	// Two-flop synchronizers
	logic [1:0] dataSync;
	logic clkPrev;	// Delayed copy for edge detection
	logic [8:0] shiftReg;	// Data bits plus parity bit
	logic parity;

	// Lines idle high, so reset to 1 to avoid a false edge
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			clkSync <= 2'b11;
			dataSync <= 2'b11;
			clkPrev <= 1'b1;
		end else begin
			clkSync <= {clkSync[0], i_ps2Clk};
			dataSync <= {dataSync[0], i_ps2Data};
			clkPrev <= clkSync[1];
		end
	end

	assign link.fallEdge = clkPrev & ~clkSync[1];
	assign link.bitVal = dataSync[1];

	// LSB arrives first, so shift right
	always_ff @(posedge i_clk) begin
		if (link.clearFrame) begin
			shiftReg <= '0;
		end else if (link.fallEdge && link.shiftEn) begin
			shiftReg <= {link.bitVal, shiftReg[8:1]};
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_rst || link.clearFrame) begin
			parity <= 1'b0;
		end else if (link.fallEdge && link.shiftEn) begin
			parity <= parity ^ link.bitVal;	// Toggle on each 1
		end
	end

	// After nine shifts the parity bit sits in bit 8
	assign link.rxByte = shiftReg[7:0];
	assign link.parityOk = parity;

endmodule

// File: source/ps2Watchdog.sv
`timescale 1ns/1ps

module ps2Watchdog #(
	parameter int TIMEOUT_CYCLES = 200
) (
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_restart,
	input  logic i_run,
	output logic o_expired
);

	localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);

	logic [CNT_W-1:0] count;

	always_ff @(posedge i_clk) begin
		if (i_rst || i_restart || !i_run) begin
			count <= '0;
		end else if (!o_expired) begin
			count <= count + 1'b1;	// Stops at the limit
		end
	end

	assign o_expired = (count == CNT_W'(TIMEOUT_CYCLES));

endmodule

// File: source/ps2FrameFsm.sv
`timescale 1ns/1ps

module ps2FrameFsm (
	input  logic i_clk,
	input  logic i_rst,
	ps2LinkIf.fsm link,
	output logic o_wdRun,
	output logic o_wdRestart,
	input  logic i_wdExpired,
	output logic o_scanValid,
	output kbdPkg::scanByte_t o_scanData,
	output logic o_frameErr
);

	kbdPkg::frameState_t state;
	logic [2:0] bitCnt;	// Data bit index

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state <= kbdPkg::idle;
			bitCnt <= '0;
			o_scanValid <= 1'b0;
			o_frameErr <= 1'b0;
		end else begin
			o_scanValid <= 1'b0;
			o_frameErr <= 1'b0;
			if (state != kbdPkg::idle && i_wdExpired) begin
				state <= kbdPkg::idle;	// Incomplete frame is dropped
			end else if (link.fallEdge) begin
				case (state)
					kbdPkg::idle: begin
						if (!link.bitVal) begin	// Start bit must be 0
							state <= kbdPkg::dataBits;
							bitCnt <= '0;
						end
					end
					kbdPkg::dataBits: begin
						bitCnt <= bitCnt + 1'b1;
						if (bitCnt == 3'd7)
							state <= kbdPkg::parityBit;
					end
					kbdPkg::parityBit: state <= kbdPkg::stopBit;
					kbdPkg::stopBit: begin
						state <= kbdPkg::idle;
						if (link.bitVal && link.parityOk)
							o_scanValid <= 1'b1;
						else
							o_frameErr <= 1'b1;
					end
					default: state <= kbdPkg::idle;
				endcase
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (link.fallEdge && state == kbdPkg::stopBit)
			o_scanData <= link.rxByte;
	end

	assign link.shiftEn = (state == kbdPkg::dataBits) || (state == kbdPkg::parityBit);
	assign link.clearFrame = (state == kbdPkg::idle);
	assign o_wdRun = (state != kbdPkg::idle);
	assign o_wdRestart = link.fallEdge && (state != kbdPkg::idle);

endmodule

// File: source/scanTranslator.sv
`timescale 1ns/1ps

module scanTranslator (
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_scanValid,
	input  kbdPkg::scanByte_t i_scanData,
	output logic o_codeValid,
	output kbdPkg::charCode_t o_codeData
);

	kbdPkg::scanByte_t hist1;	// Previous byte
	kbdPkg::scanByte_t hist2;	// Byte before that
	logic shiftOn;
	logic isShiftKey;
	logic isBreak;
	kbdPkg::charCode_t lutCode;

	// Letters share one list, shifted forms are the upper case
	function automatic kbdPkg::charCode_t lookup(input logic shiftKey,
			input kbdPkg::scanByte_t code);
		kbdPkg::charCode_t letter;
		kbdPkg::charCode_t sym;
		case (code)
			8'h1C: letter = 8'h61;	// a
			8'h32: letter = 8'h62;
			8'h21: letter = 8'h63;
			8'h23: letter = 8'h64;
			8'h24: letter = 8'h65;
			8'h2B: letter = 8'h66;
			8'h34: letter = 8'h67;
			8'h33: letter = 8'h68;
			8'h43: letter = 8'h69;
			8'h3B: letter = 8'h6A;
			8'h42: letter = 8'h6B;
			8'h4B: letter = 8'h6C;
			8'h3A: letter = 8'h6D;
			8'h31: letter = 8'h6E;
			8'h44: letter = 8'h6F;
			8'h4D: letter = 8'h70;
			8'h15: letter = 8'h71;
			8'h2D: letter = 8'h72;
			8'h1B: letter = 8'h73;
			8'h2C: letter = 8'h74;
			8'h3C: letter = 8'h75;
			8'h2A: letter = 8'h76;
			8'h1D: letter = 8'h77;
			8'h22: letter = 8'h78;
			8'h35: letter = 8'h79;
			8'h1A: letter = 8'h7A;	// z
			default: letter = 8'h00;
		endcase
		case ({shiftKey, code})
			9'h029: sym = 8'h20;	// Space
			9'h052: sym = 8'h27;	// Quote
			9'h041: sym = 8'h2C;
			9'h04E: sym = 8'h2D;
			9'h049: sym = 8'h2E;
			9'h04A: sym = 8'h2F;
			9'h045: sym = 8'h30;	// Digits 0 to 9
			9'h016: sym = 8'h31;
			9'h01E: sym = 8'h32;
			9'h026: sym = 8'h33;
			9'h025: sym = 8'h34;
			9'h02E: sym = 8'h35;
			9'h036: sym = 8'h36;
			9'h03D: sym = 8'h37;
			9'h03E: sym = 8'h38;
			9'h046: sym = 8'h39;
			9'h04C: sym = 8'h3B;
			9'h055: sym = 8'h3D;
			9'h054: sym = 8'h5B;
			9'h05D: sym = 8'h5C;	// Backslash
			9'h05B: sym = 8'h5D;
			9'h00E: sym = 8'h60;
			9'h116: sym = 8'h21;	// Shifted digit row
			9'h11E: sym = 8'h40;
			9'h126: sym = 8'h23;
			9'h125: sym = 8'h24;
			9'h12E: sym = 8'h25;
			9'h136: sym = 8'h5E;
			9'h13D: sym = 8'h26;
			9'h13E: sym = 8'h2A;
			9'h146: sym = 8'h28;
			9'h145: sym = 8'h29;
			9'h14E: sym = 8'h5F;
			9'h155: sym = 8'h2B;
			9'h152: sym = 8'h22;
			9'h14C: sym = 8'h3A;
			9'h141: sym = 8'h3C;
			9'h149: sym = 8'h3E;
			9'h14A: sym = 8'h3F;
			9'h154: sym = 8'h7B;
			9'h15D: sym = 8'h7C;
			9'h15B: sym = 8'h7D;
			9'h10E: sym = 8'h7E;
			9'h05A: sym = 8'h80;	// Enter
			9'h066: sym = 8'h81;	// Backspace
			9'h06B: sym = 8'h82;	// Left
			9'h075: sym = 8'h83;	// Up
			9'h074: sym = 8'h84;	// Right
			9'h072: sym = 8'h85;	// Down
			9'h06C: sym = 8'h86;	// Home
			9'h069: sym = 8'h87;	// End
			9'h07D: sym = 8'h88;	// Page Up
			9'h07A: sym = 8'h89;	// Page Down
			9'h070: sym = 8'h8A;	// Insert
			9'h071: sym = 8'h8B;	// Delete
			9'h076: sym = 8'h8C;	// Esc
			default: sym = 8'h00;	// Prefixes and unlisted keys
		endcase
		if (letter != 8'h00)
			return shiftKey ? letter - 8'h20 : letter;
		return sym;
	endfunction

	assign isShiftKey = (i_scanData == kbdPkg::SCAN_LSHIFT) ||
		(i_scanData == kbdPkg::SCAN_RSHIFT);
	// Reference also suppresses bytes after F0 E0
	assign isBreak = (hist1 == kbdPkg::SCAN_BREAK) ||
		(hist1 == kbdPkg::SCAN_EXT && hist2 == kbdPkg::SCAN_BREAK);
	assign lutCode = lookup(shiftOn, i_scanData);

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			hist1 <= '0;
			hist2 <= '0;
			shiftOn <= 1'b0;
			o_codeValid <= 1'b0;
		end else begin
			o_codeValid <= i_scanValid && !isBreak && (lutCode != 8'h00);
			if (i_scanValid) begin
				hist1 <= i_scanData;
				hist2 <= hist1;
				if (isShiftKey)
					shiftOn <= (hist1 != kbdPkg::SCAN_BREAK);	// Make sets, F0 clears
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_scanValid)
			o_codeData <= lutCode;
	end

endmodule

// File: source/keyFifo.sv
`timescale 1ns/1ps

module keyFifo #(
	parameter int DEPTH = 8
) (
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_push,
	input  kbdPkg::charCode_t i_pushData,
	input  logic i_pop,
	input  logic i_clearOverflow,
	output kbdPkg::charCode_t o_head,
	output logic o_empty,
	output logic o_full,
	output logic o_overflow,
	output logic [7:0] o_count
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	kbdPkg::charCode_t mem [DEPTH];
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [CNT_W-1:0] count;
	logic doPush;
	logic doPop;

	assign doPush = i_push && !o_full;	// Keyboard cannot wait, drop when full
	assign doPop = i_pop && !o_empty;

	always_ff @(posedge i_clk) begin
		if (doPush)
			mem[wrPtr] <= i_pushData;
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			o_overflow <= 1'b0;
		end else begin
			if (doPush)
				wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			if (doPop)
				rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			if (doPush && !doPop)
				count <= count + 1'b1;
			else if (doPop && !doPush)
				count <= count - 1'b1;
			if (i_push && o_full)
				o_overflow <= 1'b1;	// Set wins over clear
			else if (i_clearOverflow)
				o_overflow <= 1'b0;
		end
	end

	assign o_head = mem[rdPtr];
	assign o_empty = (count == '0);
	assign o_full = (count == CNT_W'(DEPTH));
	assign o_count = 8'(count);

endmodule

// File: source/kbdApbRegs.sv
`timescale 1ns/1ps

module kbdApbRegs (
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_psel,
	input  logic i_penable,
	input  logic i_pwrite,
	input  kbdPkg::apbAddr_t i_paddr,
	input  kbdPkg::apbWord_t i_pwdata,
	output kbdPkg::apbWord_t o_prdata,
	output logic o_pready,
	output logic o_pslverr,
	output logic o_pop,
	output logic o_clearOverflow,
	input  kbdPkg::charCode_t i_head,
	input  logic i_empty,
	input  logic i_full,
	input  logic i_overflow,
	input  logic [7:0] i_count,
	input  logic i_frameErr
);

	logic access;	// Access phase
	logic wrStatus;
	logic frameErrSeen;
	logic [7:0] errCount;

	assign access = i_psel && i_penable;
	assign wrStatus = access && i_pwrite && (i_paddr == kbdPkg::ADDR_STATUS);

	assign o_pready = 1'b1;	// No wait states
	assign o_pslverr = access && (i_paddr != kbdPkg::ADDR_DATA) &&
		(i_paddr != kbdPkg::ADDR_STATUS) && (i_paddr != kbdPkg::ADDR_ERRORS);
	assign o_pop = access && !i_pwrite && (i_paddr == kbdPkg::ADDR_DATA) && !i_empty;
	assign o_clearOverflow = wrStatus && i_pwdata[2];

	always_comb begin
		case (i_paddr)
			kbdPkg::ADDR_DATA: o_prdata = i_empty ? '0 : {24'h0, i_head};
			kbdPkg::ADDR_STATUS:
				o_prdata = {16'h0, i_count, 4'h0, frameErrSeen, i_overflow, i_full, i_empty};
			kbdPkg::ADDR_ERRORS: o_prdata = {24'h0, errCount};
			default: o_prdata = '0;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			frameErrSeen <= 1'b0;
			errCount <= '0;
		end else begin
			if (i_frameErr)
				frameErrSeen <= 1'b1;
			else if (wrStatus && i_pwdata[3])
				frameErrSeen <= 1'b0;
			if (i_frameErr && errCount != 8'hFF)
				errCount <= errCount + 1'b1;	// Saturates
		end
	end

endmodule

// File: source/kbdTop.sv
`timescale 1ns/1ps

module kbdTop #(
	parameter int FIFO_DEPTH = 8,
	parameter int TIMEOUT_CYCLES = 200
) (
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_ps2Clk,
	input  logic i_ps2Data,
	input  logic i_psel,
	input  logic i_penable,
	input  logic i_pwrite,
	input  kbdPkg::apbAddr_t i_paddr,
	input  kbdPkg::apbWord_t i_pwdata,
	output kbdPkg::apbWord_t o_prdata,
	output logic o_pready,
	output logic o_pslverr
);

	ps2LinkIf link ();

	logic wdRun, wdRestart, wdExpired;
	logic scanValid, frameErr, codeValid;
	kbdPkg::scanByte_t scanData;
	kbdPkg::charCode_t codeData, head;
	logic pop, clearOverflow, empty, full, overflow;
	logic [7:0] count;

	ps2BitReceiver bitReceiver (.i_clk, .i_rst, .i_ps2Clk, .i_ps2Data, .link(link.receiver));

	ps2Watchdog #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) watchdog (.i_clk, .i_rst,
		.i_restart(wdRestart), .i_run(wdRun), .o_expired(wdExpired));

	ps2FrameFsm frameFsm (.i_clk, .i_rst, .link(link.fsm), .o_wdRun(wdRun),
		.o_wdRestart(wdRestart), .i_wdExpired(wdExpired), .o_scanValid(scanValid),
		.o_scanData(scanData), .o_frameErr(frameErr));

	scanTranslator translator (.i_clk, .i_rst, .i_scanValid(scanValid),
		.i_scanData(scanData), .o_codeValid(codeValid), .o_codeData(codeData));

	keyFifo #(.DEPTH(FIFO_DEPTH)) fifo (.i_clk, .i_rst, .i_push(codeValid),
		.i_pushData(codeData), .i_pop(pop), .i_clearOverflow(clearOverflow), .o_head(head),
		.o_empty(empty), .o_full(full), .o_overflow(overflow), .o_count(count));

	kbdApbRegs apbRegs (.i_clk, .i_rst, .i_psel, .i_penable, .i_pwrite, .i_paddr,
		.i_pwdata, .o_prdata, .o_pready, .o_pslverr, .o_pop(pop),
		.o_clearOverflow(clearOverflow), .i_head(head), .i_empty(empty), .i_full(full),
		.i_overflow(overflow), .i_count(count), .i_frameErr(frameErr));

endmodule

// File: tb/kbdChecker.sv
`timescale 1ns/1ps

module kbdChecker (
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_psel,
	input  logic i_penable,
	input  logic i_pwrite,
	input  kbdPkg::apbAddr_t i_paddr,
	input  kbdPkg::apbWord_t i_prdata,
	input  logic i_pready,
	input  logic i_pslverr,
	input  logic i_expValid,
	input  logic i_expCheck,
	input  logic i_expErr,
	input  kbdPkg::apbWord_t i_expData,
	output int o_errors
);

	typedef struct packed {
		logic check;	// Compare the data word too
		logic slvErr;
		kbdPkg::apbWord_t data;
	} readExp_t;

	readExp_t expQ [$];	// One entry per APB read, in issue order
	readExp_t cur;

	always @(posedge i_clk) begin
		if (i_rst) begin
			expQ.delete();
			o_errors = 0;
		end else begin
			if (i_expValid)
				expQ.push_back({i_expCheck, i_expErr, i_expData});
			if (i_psel && i_penable && !i_pwrite) begin	// Read access phase
				if (i_pready !== 1'b1) begin
					$display("ERROR: PREADY low during a read at offset 0x%h", i_paddr);
					o_errors = o_errors + 1;
				end
				if (expQ.size() == 0) begin
					$display("ERROR: read at offset 0x%h with no expected value queued",
						i_paddr);
					o_errors = o_errors + 1;
				end else begin
					cur = expQ.pop_front();
					if (i_pslverr !== cur.slvErr) begin
						$display("MISMATCH o_pslverr at offset 0x%h: got 0x%h, expected 0x%h",
							i_paddr, i_pslverr, cur.slvErr);
						o_errors = o_errors + 1;
					end
					if (cur.check && i_prdata !== cur.data) begin
						$display("MISMATCH o_prdata at offset 0x%h: got 0x%08h, expected 0x%08h",
							i_paddr, i_prdata, cur.data);
						o_errors = o_errors + 1;
					end
				end
			end
		end
	end

endmodule

// File: tb/kbdTb.sv
`timescale 1ns/1ps

module kbdTb;

	localparam int FIFO_DEPTH = 8;
	localparam int TIMEOUT_CYCLES = 200;
	localparam int PS2_HALF = 8;	// Half of the 16-cycle PS/2 clock
	localparam int MAX_ENTRIES = 8;
	localparam int POLL_LIMIT = 100;
	localparam int DRAIN_LIMIT = 16;
	localparam int MODE_GOOD = 0;
	localparam int MODE_BAD_PARITY = 1;	// First frame has a wrong parity bit
	localparam int MODE_CUT = 2;	// First frame stops after 4 bits

	logic clk, rst, ps2Clk, ps2Data;
	logic psel, penable, pwrite, pready, pslverr;
	kbdPkg::apbAddr_t paddr;
	kbdPkg::apbWord_t pwdata, prdata;
	logic expValid, expCheck, expErr;
	kbdPkg::apbWord_t expData;
	int chkErrors;
	int tbErrors;
	logic aborted;

	// Bytes and codes are right aligned with the first one leftmost
	int entryCnt;
	int nBytes [MAX_ENTRIES];
	logic [95:0] byteVec [MAX_ENTRIES];
	int mode [MAX_ENTRIES];
	int nCodes [MAX_ENTRIES];
	logic [63:0] codeVec [MAX_ENTRIES];
	logic clrSticky [MAX_ENTRIES];	// Write STATUS to clear flags after draining
	kbdPkg::apbWord_t expStatus [MAX_ENTRIES];
	kbdPkg::apbWord_t expErrCnt [MAX_ENTRIES];

	kbdTop #(.FIFO_DEPTH(FIFO_DEPTH), .TIMEOUT_CYCLES(TIMEOUT_CYCLES)) i_dut (
		.i_clk(clk), .i_rst(rst), .i_ps2Clk(ps2Clk), .i_ps2Data(ps2Data),
		.i_psel(psel), .i_penable(penable), .i_pwrite(pwrite), .i_paddr(paddr),
		.i_pwdata(pwdata), .o_prdata(prdata), .o_pready(pready), .o_pslverr(pslverr));

	kbdChecker readChecker (.i_clk(clk), .i_rst(rst), .i_psel(psel), .i_penable(penable),
		.i_pwrite(pwrite), .i_paddr(paddr), .i_prdata(prdata), .i_pready(pready),
		.i_pslverr(pslverr), .i_expValid(expValid), .i_expCheck(expCheck),
		.i_expErr(expErr), .i_expData(expData), .o_errors(chkErrors));

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic addEntry(input int nb, input logic [95:0] bv, input int md, input int nc,
			input logic [63:0] cv, input logic clr, input kbdPkg::apbWord_t st,
			input kbdPkg::apbWord_t ec);
		nBytes[entryCnt] = nb;
		byteVec[entryCnt] = bv;
		mode[entryCnt] = md;
		nCodes[entryCnt] = nc;
		codeVec[entryCnt] = cv;
		clrSticky[entryCnt] = clr;
		expStatus[entryCnt] = st;
		expErrCnt[entryCnt] = ec;
		entryCnt++;
	endtask

	task automatic loadTable();
		addEntry(9, 96'h1C_F0_1C_32_F0_32_45_F0_45, MODE_GOOD, 3, 64'h61_62_30, 1'b0,
			32'h0300, 32'h0);
		addEntry(6, 96'h12_1C_16_F0_12_1C, MODE_GOOD, 3, 64'h41_21_61, 1'b0, 32'h0300, 32'h0);
		addEntry(6, 96'hE0_75_E0_F0_75_5A, MODE_GOOD, 2, 64'h83_80, 1'b0, 32'h0200, 32'h0);
		addEntry(1, 96'h1C, MODE_BAD_PARITY, 0, 64'h0, 1'b1, 32'h0009, 32'h1);
		addEntry(1, 96'h29, MODE_GOOD, 1, 64'h20, 1'b0, 32'h0100, 32'h1);
		addEntry(9, 96'h1C_32_21_23_24_2B_34_33_43, MODE_GOOD, 8,
			64'h61_62_63_64_65_66_67_68, 1'b1, 32'h0806, 32'h1);	// One more than the depth
		addEntry(2, 96'h1C_1C, MODE_CUT, 1, 64'h61, 1'b0, 32'h0100, 32'h1);
	endtask

	function automatic logic [7:0] tableByte(input int e, input int k);
		return byteVec[e][8*(nBytes[e]-1-k) +: 8];
	endfunction

	// Start, 8 data bits LSB first, odd parity, stop
	task automatic sendFrame(input logic [7:0] b, input logic badParity, input int nBits);
		logic [10:0] frame;
		int i;
		int gap;
		frame = {1'b1, ~(^b) ^ badParity, b, 1'b0};
		for (i = 0; i < nBits; i++) begin
			@(posedge clk);
			ps2Data <= frame[i];
			repeat (PS2_HALF - 1) @(posedge clk);
			ps2Clk <= 1'b0;	// Device changes data while clock is high
			repeat (PS2_HALF) @(posedge clk);
			ps2Clk <= 1'b1;
		end
		@(posedge clk);
		ps2Data <= 1'b1;
		gap = $urandom_range(60, 20);
		repeat (gap) @(posedge clk);
	endtask

	task automatic apbRead(input kbdPkg::apbAddr_t addr, input logic check,
			input kbdPkg::apbWord_t exp, input logic slvErr, output kbdPkg::apbWord_t data);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= addr;
		expValid <= 1'b1;
		expCheck <= check;
		expData <= exp;
		expErr <= slvErr;
		@(posedge clk);
		penable <= 1'b1;
		expValid <= 1'b0;
		@(negedge clk);
		data = prdata;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apbWrite(input kbdPkg::apbAddr_t addr, input kbdPkg::apbWord_t data);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b1;
		paddr <= addr;
		pwdata <= data;
		@(posedge clk);
		penable <= 1'b1;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	function automatic logic statusSettled(input kbdPkg::apbWord_t st, input int e);
		return (int'(st[15:8]) == nCodes[e]) && (mode[e] != MODE_BAD_PARITY || st[3]);
	endfunction

	task automatic waitStatus(input int e);
		kbdPkg::apbWord_t st;
		int polls;
		polls = 0;
		apbRead(kbdPkg::ADDR_STATUS, 1'b0, '0, 1'b0, st);
		while (!statusSettled(st, e) && polls < POLL_LIMIT) begin
			polls++;
			apbRead(kbdPkg::ADDR_STATUS, 1'b0, '0, 1'b0, st);
		end
		if (!statusSettled(st, e)) begin
			$display("ERROR: entry %0d timed out waiting for STATUS to settle", e);
			tbErrors++;
			aborted = 1'b1;
		end
	endtask

	task automatic drainFifo(input int e);
		kbdPkg::apbWord_t st;
		kbdPkg::apbWord_t data;
		kbdPkg::apbWord_t exp;
		int n;
		n = 0;
		apbRead(kbdPkg::ADDR_STATUS, 1'b0, '0, 1'b0, st);
		while (!st[0] && n < DRAIN_LIMIT) begin
			exp = (n < nCodes[e]) ? {24'h0, codeVec[e][8*(nCodes[e]-1-n) +: 8]} : '0;
			apbRead(kbdPkg::ADDR_DATA, 1'b1, exp, 1'b0, data);
			n++;
			apbRead(kbdPkg::ADDR_STATUS, 1'b0, '0, 1'b0, st);
		end
		if (!st[0]) begin
			$display("ERROR: entry %0d timed out draining the FIFO", e);
			tbErrors++;
			aborted = 1'b1;
		end else if (n != nCodes[e]) begin
			$display("ERROR: entry %0d read back %0d codes, %0d expected", e, n, nCodes[e]);
			tbErrors++;
		end
		apbRead(kbdPkg::ADDR_DATA, 1'b1, '0, 1'b0, data);	// Empty FIFO reads as 0
	endtask

	initial begin
		int e;
		int k;
		kbdPkg::apbWord_t rd;
		void'($urandom(32));
		rst = 1'b1;
		ps2Clk = 1'b1;
		ps2Data = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		expValid = 1'b0;
		expCheck = 1'b0;
		expErr = 1'b0;
		expData = '0;
		tbErrors = 0;
		aborted = 1'b0;
		entryCnt = 0;
		loadTable();
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		for (e = 0; e < entryCnt && !aborted; e++) begin
			for (k = 0; k < nBytes[e]; k++) begin
				if (k == 0 && mode[e] == MODE_CUT) begin
					sendFrame(tableByte(e, k), 1'b0, 4);
					repeat (TIMEOUT_CYCLES + 50) @(posedge clk);	// Watchdog drops the frame
				end else begin
					sendFrame(tableByte(e, k), (k == 0) && (mode[e] == MODE_BAD_PARITY), 11);
				end
			end
			waitStatus(e);
			if (!aborted) begin
				apbRead(kbdPkg::ADDR_STATUS, 1'b1, expStatus[e], 1'b0, rd);
				apbRead(kbdPkg::ADDR_ERRORS, 1'b1, expErrCnt[e], 1'b0, rd);
				drainFifo(e);
			end
			if (!aborted && clrSticky[e]) begin
				apbWrite(kbdPkg::ADDR_STATUS, 32'h0C);
				apbRead(kbdPkg::ADDR_STATUS, 1'b1, 32'h1, 1'b0, rd);	// Only empty left
			end
		end
		if (!aborted)
			apbRead(4'hC, 1'b1, '0, 1'b1, rd);	// Unmapped offset
		repeat (2) @(posedge clk);
		$display("errors: checker %0d, testbench %0d", chkErrors, tbErrors);
		if (chkErrors == 0 && tbErrors == 0 && !aborted)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// File: all.f
source/kbdPkg.sv
source/ps2LinkIf.sv
source/ps2BitReceiver.sv
source/ps2Watchdog.sv
source/ps2FrameFsm.sv
source/scanTranslator.sv
source/keyFifo.sv
source/kbdApbRegs.sv
source/kbdTop.sv
tb/kbdChecker.sv
tb/kbdTb.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing -Wno-fatal -f all.f --top-module kbdTb -Mdir obj_dir \
	&& ./obj_dir/VkbdTb | tee /dev/stderr | grep -qx "sim passed" \
	&& echo "PASS" || { echo "FAIL"; exit 1; }
